/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpc_ram_tb -f vlog.f -o cpc_ram_sim \
  && ./obj_dir/cpc_ram_sim | tee /dev/stderr | grep -q "^Simulation finished: PASS$" \
  && echo "run_sim: passed" \
  || { echo "run_sim: failed"; exit 1; }

/* sim/cpc_ram_tests.svh */
// Directed tests for the RAM expansion controller.
// Included into the testbench top, where the model and compare tasks live.

// New bus value 1 ns after the next rising edge
task automatic drive(input cpu_bus_t b);
  @(posedge clk);
  #1;
  bus = b;
endtask

// Memory cycle with RD or WR low depending on is_wr
function automatic cpu_bus_t mem_bus(input logic a15, input logic a14, input logic is_wr);
  cpu_bus_t b;
  b        = idle_bus();
  b.adr15  = a15;
  b.adr14  = a14;
  b.mreq_b = 1'b0;
  b.rd_b   = is_wr;
  b.wr_b   = !is_wr;
  return b;
endfunction

// I/O write with A15 low, the model takes the new state after the write edge
task automatic io_write(input logic a8, input cpu_data_t data);
  cpu_bus_t b;
  b        = idle_bus();
  b.iorq_b = 1'b0;
  b.wr_b   = 1'b0;
  b.adr8   = a8;
  b.data   = data;
  drive(b);
  drive(idle_bus());
  if (data[7:6] == CMD_RAM_CTRL) begin
    m_cfg.card_sel = PORT_7E_SEL ? !a8 : a8;
    m_cfg.bank     = bank_t'(data[5:3]);
    m_cfg.scheme   = scheme_e'(data[2:0]);
  end else if (data[7:6] == CMD_ROM_CTRL) begin
    m_rom.upper_dis = data[3];
    m_rom.lower_dis = data[2];
  end
endtask

task automatic ram_cmd(input logic a8, input bank_t bk, input scheme_e sch);
  io_write(a8, {CMD_RAM_CTRL, bk, sch});
endtask

// Outputs are combinational, so they are read in the middle of the cycle
task automatic check_access(input cpu_bus_t b, input logic c3_a15, input string what);
  ram_ctrl_t exp;
  drive(b);
  #4;
  exp = model_ctrl(b, c3_a15);
  check_ctrl(ram, exp, what);
  if (exp.ramdis) begin
    check_adr(ram.ramadrhi, exp.ramadrhi, what);
  end
endtask

// One-cycle memory access followed by an idle cycle
task automatic mem_access(input logic a15, input logic a14, input logic is_wr,
                          input string what);
  check_access(mem_bus(a15, a14, is_wr), a15, what);
  drive(idle_bus());
endtask

task automatic test_reset_defaults();
  for (int sl = 0; sl < 4; sl++) begin
    mem_access(sl[1], sl[0], 1'b0, $sformatf("reset read slot %0d", sl));
    mem_access(sl[1], sl[0], 1'b1, $sformatf("reset write slot %0d", sl));
  end
endtask

task automatic test_port_select();
  bank_t bk;
  pick_bank(bk);
  // The card sits on 7Fxx, so a write to 7Exx leaves it deselected
  ram_cmd(1'b0, bk, SCH_ALL_SLOTS);
  mem_access(1'b1, 1'b0, 1'b1, "port 7Exx write");
  ram_cmd(1'b1, bk, SCH_ALL_SLOTS);
  mem_access(1'b1, 1'b0, 1'b1, "port 7Fxx write");
endtask

task automatic test_scheme_map();
  bank_t bk;
  for (int s = 0; s < 8; s++) begin
    pick_bank(bk);
    ram_cmd(1'b1, bk, scheme_e'(s[2:0]));
    for (int sl = 0; sl < 4; sl++) begin
      mem_access(sl[1], sl[0], 1'b1, $sformatf("scheme %0d slot %0d", s, sl));
    end
  end
endtask

task automatic test_rom_gating();
  bank_t bk;
  pick_bank(bk);
  ram_cmd(1'b1, bk, SCH_ALL_SLOTS);
  // Walk all four combinations of upper and lower ROM disable
  for (int p = 0; p < 4; p++) begin
    io_write(1'b0, {CMD_ROM_CTRL, 2'b00, p[1], p[0], 2'b00});
    for (int sl = 0; sl < 4; sl++) begin
      mem_access(sl[1], sl[0], 1'b0, $sformatf("rom %0d read slot %0d", p, sl));
      mem_access(sl[1], sl[0], 1'b1, $sformatf("rom %0d write slot %0d", p, sl));
    end
  end
endtask

task automatic test_c3_latch();
  bank_t    bk;
  cpu_bus_t b;
  pick_bank(bk);
  ram_cmd(1'b1, bk, SCH_C3);
  b = mem_bus(1'b1, 1'b1, 1'b1);
  check_access(b, 1'b1, "c3 cycle start");
  // A15 drops after the start edge but the latched copy keeps the hit
  b.adr15 = 1'b0;
  check_access(b, 1'b1, "c3 after A15 drop");
  check_access(b, 1'b1, "c3 held cycle");
  drive(idle_bus());
  // A cycle that starts in slot 1 is not mapped
  mem_access(1'b0, 1'b1, 1'b1, "c3 slot 1");
endtask

task automatic test_refresh();
  bank_t    bk;
  cpu_bus_t b;
  pick_bank(bk);
  ram_cmd(1'b1, bk, SCH_ALL_SLOTS);
  for (int sl = 0; sl < 4; sl++) begin
    b        = mem_bus(sl[1], sl[0], 1'b0);
    b.rd_b   = 1'b1;
    b.rfsh_b = 1'b0;
    check_access(b, b.adr15, $sformatf("refresh slot %0d", sl));
    drive(idle_bus());
  end
endtask

/* sim/cpc_ram_tb.sv */
// Testbench top for the CPC 512K RAM expansion controller.
// Holds the DUT, a reference model of the mapping and strobe rules, the
// compare tasks and the watchdog. The directed tests come from a header.

`timescale 1ns/1ps

module cpc_ram_tb
  import cpc_ram_pkg::*;
();

  localparam int CLK_PERIOD_NS = 10;
  localparam bit PORT_7E_SEL   = 1'b0;
  // Rough length of all tests in cycles, with a wide margin on top
  localparam int EST_CYCLES    = 400;
  localparam int WATCHDOG_NS   = EST_CYCLES * CLK_PERIOD_NS * 5;

  logic       clk;
  logic       reset_b_w;
  cpu_bus_t   bus;
  ram_ctrl_t  ram;

  // Expected register contents, updated by the I/O write task
  bank_cfg_t  m_cfg;
  rom_state_t m_rom;

  logic [31:0] rng_state = 32'd93682;
  int          err_ctrl  = 0;
  int          err_adr   = 0;
  int          n_checks  = 0;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (5)
  ) clk_gen_i (
    .clk       (clk),
    .reset_b_w (reset_b_w)
  );

  cpc_ram_top #(
    .PORT_7E_SEL (PORT_7E_SEL)
  ) dut_i (
    .clk       (clk),
    .reset_b_w (reset_b_w),
    .bus       (bus),
    .ram       (ram)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic pick_bank(output bank_t bk);
    rng_state = xorshift32(rng_state);
    bk = bank_t'(rng_state[10:8]);
  endtask

  // Bus at rest with every strobe inactive
  function automatic cpu_bus_t idle_bus();
    cpu_bus_t b;
    b        = '0;
    b.iorq_b = 1'b1;
    b.mreq_b = 1'b1;
    b.rd_b   = 1'b1;
    b.wr_b   = 1'b1;
    b.rfsh_b = 1'b1;
    return b;
  endfunction

  // Reference model of the slot mapping and the SRAM strobes
  // c3_a15 is the A15 that scheme 3 judges the slot on
  function automatic ram_ctrl_t model_ctrl(input cpu_bus_t b, input logic c3_a15);
    block_t    slot;
    block_t    blk;
    logic      hit;
    logic      active;
    logic      rom_off;
    ram_ctrl_t r;
    slot = {b.adr15, b.adr14};
    blk  = slot;
    hit  = 1'b0;
    case (m_cfg.scheme)
      SCH_INTERNAL: hit = 1'b0;
      SCH_TOP_SLOT: begin
        hit = (slot == 2'd3);
        blk = 2'd3;
      end
      SCH_ALL_SLOTS: hit = 1'b1;
      SCH_C3: begin
        hit = ({c3_a15, b.adr14} == 2'b11);
        blk = 2'd3;
      end
      default: begin
        // Schemes 4 to 7 put block 0 to 3 into slot 1
        hit = (slot == 2'd1);
        blk = block_t'(m_cfg.scheme - SCH_SLOT1_B0);
      end
    endcase
    hit        = hit && m_cfg.card_sel;
    active     = !b.mreq_b && b.rfsh_b && hit;
    rom_off    = b.adr15 ? m_rom.upper_dis : m_rom.lower_dis;
    r.ramcs_b  = !active;
    r.ramwe_b  = !(active && !b.wr_b);
    r.ramoe_b  = !(active && !b.rd_b && rom_off);
    r.ramdis   = hit;
    r.ramadrhi = {m_cfg.bank, blk};
    return r;
  endfunction

  // Strobes and RAMDIS, the address is compared on its own
  task automatic check_ctrl(input ram_ctrl_t got, input ram_ctrl_t exp, input string what);
    n_checks++;
    if (got.ramcs_b !== exp.ramcs_b || got.ramoe_b !== exp.ramoe_b ||
        got.ramwe_b !== exp.ramwe_b || got.ramdis !== exp.ramdis) begin
      err_ctrl++;
      $display("[ERROR] t=%0d ns %s: cs_b oe_b we_b ramdis got %b%b%b%b expected %b%b%b%b",
               $time, what, got.ramcs_b, got.ramoe_b, got.ramwe_b, got.ramdis,
               exp.ramcs_b, exp.ramoe_b, exp.ramwe_b, exp.ramdis);
    end
  endtask

  task automatic check_adr(input ram_adr_hi_t got, input ram_adr_hi_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      err_adr++;
      $display("[ERROR] t=%0d ns %s: ramadrhi got %b expected %b", $time, what, got, exp);
    end
  endtask

  `include "cpc_ram_tests.svh"

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    bus   = idle_bus();
    m_cfg = '{card_sel: 1'b0, bank: '0, scheme: SCH_INTERNAL};
    m_rom = '{upper_dis: 1'b0, lower_dis: 1'b0};
    wait (reset_b_w === 1'b1);
    test_reset_defaults();
    test_port_select();
    test_scheme_map();
    test_rom_gating();
    test_c3_latch();
    test_refresh();
    $display("Checks run: %0d, control errors: %0d, address errors: %0d",
             n_checks, err_ctrl, err_adr);
    if (err_ctrl + err_adr == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* sim/tb_clock_gen.sv */
// Clock and reset source for the RAM expansion testbench.
// Gives a free-running clock and holds the synchronous reset low for a few cycles.

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic reset_b_w
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD_NS / 2) clk = ~clk;

  // Reset is released just after an edge, like the other testbench inputs
  initial begin
    reset_b_w = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset_b_w = 1'b1;
  end

endmodule

/* src/bank_mapper.sv */
// Maps the CPU 16K slot onto a block of the selected expansion bank.
// Scheme 3 looks at an A15 latched when the memory cycle starts, since
// the CPU address may move under it before the cycle ends.

`timescale 1ns/1ps

module bank_mapper
  import cpc_ram_pkg::*;
(
  input  logic        clk,
  input  logic        reset_b_w,
  input  cpu_bus_t    bus,
  input  bank_cfg_t   cfg,
  output map_result_t map
);

  logic       mreq_b_q;
  logic       adr15_q;
  logic       cyc_start;
  logic       cyc_held;
  logic       adr15_eff;
  block_t     slot;
  block_t     slot_c3;
  logic [2:0] scheme_bits;
  logic       hit;
  block_t     block;

  // Registered MREQ marks the first clock edge of a memory cycle
  always_ff @(posedge clk) begin
    if (!reset_b_w) begin
      mreq_b_q <= 1'b1;
    end else begin
      mreq_b_q <= bus.mreq_b;
    end
  end

  // MREQ low now but high at the previous edge
  assign cyc_start = !bus.mreq_b && mreq_b_q;

  // A15 captured on that first edge
  // It is only read while cyc_held is set, which needs mreq_b_q low
  always_ff @(posedge clk) begin
    if (cyc_start) begin
      adr15_q <= bus.adr15;
    end
  end

  // After the start edge and until MREQ rises the latched copy applies
  assign cyc_held  = !bus.mreq_b && !mreq_b_q;
  assign adr15_eff = cyc_held ? adr15_q : bus.adr15;

  // Live slot for every scheme except C3
  assign slot    = {bus.adr15, bus.adr14};
  assign slot_c3 = {adr15_eff, bus.adr14};

  assign scheme_bits = cfg.scheme;

  // Scheme decode
  // On a miss the block follows the live slot so the address stays defined
  always_comb begin
    hit   = 1'b0;
    block = slot;
    unique case (cfg.scheme)
      SCH_INTERNAL: begin
        // All four slots stay in the CPC internal RAM
        hit = 1'b0;
      end
      SCH_TOP_SLOT: begin
        // Only C000-FFFF is swapped
        if (slot == 2'd3) begin
          hit   = 1'b1;
          block = 2'd3;
        end
      end
      SCH_ALL_SLOTS: begin
        // The whole 64K bank replaces internal RAM
        hit   = 1'b1;
        block = slot;
      end
      SCH_C3: begin
        // C000-FFFF comes from block 3, judged on the latched A15
        if (slot_c3 == 2'd3) begin
          hit   = 1'b1;
          block = 2'd3;
        end
      end
      SCH_SLOT1_B0, SCH_SLOT1_B1, SCH_SLOT1_B2, SCH_SLOT1_B3: begin
        // 4000-7FFF shows the block named by the low two scheme bits
        if (slot == 2'd1) begin
          hit   = 1'b1;
          block = block_t'(scheme_bits[1:0]);
        end
      end
    endcase
  end

  // Nothing maps unless this card was addressed by the last RAM control write
  assign map.exp_hit = cfg.card_sel && hit;
  assign map.adr_hi  = {cfg.bank, block};

  // Scheme 3 stays on block 3 for the whole cycle once it has started there
  a_c3_hold: assert property (
    @(posedge clk) disable iff (!reset_b_w)
    (cfg.scheme == SCH_C3) && cyc_held && map.exp_hit && !bus.mreq_b
      ##1 (!bus.mreq_b && $stable(cfg))
    |-> map.exp_hit && (map.adr_hi[1:0] == 2'd3)
  );

endmodule

/* src/cpc_ram_pkg.sv */
// Shared types for the CPC 512K RAM expansion controller.
// Holds the field widths, the CPU bus and SRAM control bundles and the
// block scheme encoding. Modules pull it in with a wildcard import.

package cpc_ram_pkg;

  // Field widths
  localparam int CPU_DATA_W = 8;
  localparam int BANK_W     = 3;
  localparam int BLOCK_W    = 2;
  localparam int ADR_HI_W   = BANK_W + BLOCK_W;

  // One byte on the Z80 data bus
  typedef logic [CPU_DATA_W-1:0] cpu_data_t;

  // A 64K bank of the 512K expansion
  typedef logic [BANK_W-1:0] bank_t;

  // A 16K block inside a bank, or a 16K slot of the CPU address space
  typedef logic [BLOCK_W-1:0] block_t;

  // SRAM address bits 18:14, bank above block
  typedef logic [ADR_HI_W-1:0] ram_adr_hi_t;

  // Block switching schemes selected by data bits 2:0 of a RAM control write
  typedef enum logic [2:0] {
    SCH_INTERNAL  = 3'd0,
    SCH_TOP_SLOT  = 3'd1,
    SCH_ALL_SLOTS = 3'd2,
    SCH_C3        = 3'd3,
    SCH_SLOT1_B0  = 3'd4,
    SCH_SLOT1_B1  = 3'd5,
    SCH_SLOT1_B2  = 3'd6,
    SCH_SLOT1_B3  = 3'd7
  } scheme_e;

  // The Z80 signals the controller watches, all active low except address and data
  typedef struct packed {
    logic      adr15;
    logic      adr14;
    logic      adr8;
    logic      iorq_b;
    logic      mreq_b;
    logic      rd_b;
    logic      wr_b;
    logic      rfsh_b;
    cpu_data_t data;
  } cpu_bus_t;

  // Bank register contents as loaded by a RAM control write
  typedef struct packed {
    logic    card_sel;
    bank_t   bank;
    scheme_e scheme;
  } bank_cfg_t;

  // ROM disable flags from the ROM control register
  typedef struct packed {
    logic upper_dis;
    logic lower_dis;
  } rom_state_t;

  // Result of mapping the current CPU slot through the scheme
  typedef struct packed {
    logic        exp_hit;
    ram_adr_hi_t adr_hi;
  } map_result_t;

  // Pins towards the expansion SRAM and the CPC RAMDIS line
  typedef struct packed {
    logic        ramcs_b;
    logic        ramoe_b;
    logic        ramwe_b;
    logic        ramdis;
    ram_adr_hi_t ramadrhi;
  } ram_ctrl_t;

  // Command field in data bits 7:6 of an I/O write
  localparam logic [1:0] CMD_RAM_CTRL = 2'b11;
  localparam logic [1:0] CMD_ROM_CTRL = 2'b10;

endpackage

/* src/cpc_ram_top.sv */
// Top level of the CPC 512K RAM expansion controller.
// Takes the Z80 bus and drives the SRAM high address, its strobes and
// RAMDIS. PORT_7E_SEL picks the I/O port the card answers on.

`timescale 1ns/1ps

module cpc_ram_top
  import cpc_ram_pkg::*;
#(
  // 0 for 7Fxx, 1 for 7Exx
  parameter bit PORT_7E_SEL = 1'b0
) (
  input  logic      clk,
  input  logic      reset_b_w,
  input  cpu_bus_t  bus,
  output ram_ctrl_t ram
);

  bank_cfg_t   cfg;
  rom_state_t  rom;
  map_result_t map;

  // Configuration registers written by CPU I/O cycles
  expansion_ctrl_regs #(
    .PORT_7E_SEL (PORT_7E_SEL)
  ) u_ctrl_regs (
    .clk       (clk),
    .reset_b_w (reset_b_w),
    .bus       (bus),
    .cfg       (cfg),
    .rom       (rom)
  );

  // Slot to block mapping with the scheme 3 A15 latch
  bank_mapper u_bank_mapper (
    .clk       (clk),
    .reset_b_w (reset_b_w),
    .bus       (bus),
    .cfg       (cfg),
    .map       (map)
  );

  // SRAM strobes and RAMDIS
  ram_strobe_gen u_strobe_gen (
    .clk (clk),
    .bus (bus),
    .cfg (cfg),
    .rom (rom),
    .map (map),
    .ram (ram)
  );

endmodule

/* src/expansion_ctrl_regs.sv */
// I/O write decoder and configuration registers of the RAM expansion.
// Captures the bank/scheme byte and the ROM disable bits written by the CPU
// and presents them to the mapper and the strobe generator.

`timescale 1ns/1ps

module expansion_ctrl_regs
  import cpc_ram_pkg::*;
#(
  // 0 answers on port 7Fxx, 1 answers on port 7Exx
  parameter bit PORT_7E_SEL = 1'b0
) (
  input  logic       clk,
  input  logic       reset_b_w,
  input  cpu_bus_t   bus,
  output bank_cfg_t  cfg,
  output rom_state_t rom
);

  logic       io_wr;
  logic       ram_sel;
  logic       rom_sel;
  logic       port_match;
  bank_cfg_t  cfg_q;
  rom_state_t rom_q;

  // The gate array decodes its registers with A15 low, so the card does the same
  assign io_wr = !bus.iorq_b && !bus.wr_b && !bus.adr15;

  // Command type comes from the two top data bits
  assign ram_sel = io_wr && (bus.data[7:6] == CMD_RAM_CTRL);
  assign rom_sel = io_wr && (bus.data[7:6] == CMD_ROM_CTRL);

  // A8 tells 7Fxx from 7Exx
  // A second card can then sit on the other port
  assign port_match = PORT_7E_SEL ? !bus.adr8 : bus.adr8;

  // Bank register
  always_ff @(posedge clk) begin
    if (!reset_b_w) begin
      cfg_q.card_sel <= 1'b0;
      cfg_q.bank     <= '0;
      cfg_q.scheme   <= SCH_INTERNAL;
    end else if (ram_sel) begin
      // Every RAM control write reloads the selection
      // A write to the other port deselects this card
      cfg_q.card_sel <= port_match;
      cfg_q.bank     <= bank_t'(bus.data[5:3]);
      cfg_q.scheme   <= scheme_e'(bus.data[2:0]);
    end
  end

  // ROM control register
  // Bit 3 disables the upper ROM and bit 2 the lower ROM
  always_ff @(posedge clk) begin
    if (!reset_b_w) begin
      rom_q.upper_dis <= 1'b0;
      rom_q.lower_dis <= 1'b0;
    end else if (rom_sel) begin
      rom_q.upper_dis <= bus.data[3];
      rom_q.lower_dis <= bus.data[2];
    end
  end

  assign cfg = cfg_q;
  assign rom = rom_q;

  // The two commands share the write strobe but never the command field
  a_single_cmd: assert property (
    @(posedge clk) disable iff (!reset_b_w)
    !(ram_sel && rom_sel)
  );

endmodule

/* src/ram_strobe_gen.sv */
// SRAM strobe and RAMDIS generation for the RAM expansion.
// Pure combinational path from the CPU bus to the SRAM pins. The clock
// only samples the protocol checks.

`timescale 1ns/1ps

module ram_strobe_gen
  import cpc_ram_pkg::*;
(
  input  logic        clk,
  input  cpu_bus_t    bus,
  input  bank_cfg_t   cfg,
  input  rom_state_t  rom,
  input  map_result_t map,
  output ram_ctrl_t   ram
);

  logic active;
  logic rom_off;

  // Refresh cycles put the refresh address on the bus and must not hit the SRAM
  assign active = !bus.mreq_b && bus.rfsh_b && map.exp_hit;

  // A read only comes from RAM when the ROM over that half is paged out
  assign rom_off = bus.adr15 ? rom.upper_dis : rom.lower_dis;

  always_comb begin
    ram.ramcs_b  = !active;
    ram.ramwe_b  = !(active && !bus.wr_b);
    ram.ramoe_b  = !(active && !bus.rd_b && rom_off);
    // Internal RAM is held off for the whole mapped slot, refresh included
    ram.ramdis   = map.exp_hit;
    ram.ramadrhi = map.adr_hi;
  end

  // Output and write enable would fight on the SRAM data pins
  a_oe_we_excl: assert property (
    @(posedge clk)
    !(!ram.ramoe_b && !ram.ramwe_b)
  );

  // Chip select belongs to a memory cycle
  a_cs_in_mreq: assert property (
    @(posedge clk)
    !ram.ramcs_b |-> !bus.mreq_b
  );

  // A selected SRAM needs a card addressed with a scheme other than internal
  a_cs_needs_cfg: assert property (
    @(posedge clk)
    !ram.ramcs_b |-> cfg.card_sel && (cfg.scheme != SCH_INTERNAL)
  );

endmodule

/* vlog.f */
+incdir+sim
src/cpc_ram_pkg.sv
src/expansion_ctrl_regs.sv
src/bank_mapper.sv
src/ram_strobe_gen.sv
src/cpc_ram_top.sv
sim/tb_clock_gen.sv
sim/cpc_ram_tb.sv
